// File: common/cpuTypesPkg.sv
package cpuTypesPkg;

    // one machine word
    localparam int DataWidth = 32;

    // bits of one register address and of one shift amount
    localparam int RegAddrWidth = 5;
    localparam int ShamtWidth = 5;

    typedef logic [DataWidth-1:0] wordT;       // datapath word
    typedef logic [RegAddrWidth-1:0] regAddrT; // gpr index
    typedef logic [ShamtWidth-1:0] shamtT;     // immediate bits 10..6

endpackage

// File: common/exeCtrlPkg.sv
package exeCtrlPkg;

    // zero is ADD, so a cleared register holds a harmless op
    typedef enum logic [3:0] {
        ADD  = 4'd0,
        SUB  = 4'd1,
        AND  = 4'd2,
        OR   = 4'd3,
        XOR  = 4'd4,
        NOR  = 4'd5,
        SLT  = 4'd6,
        SLTU = 4'd7,
        SLL  = 4'd8,
        SRL  = 4'd9,
        SRA  = 4'd10,
        LUI  = 4'd11,
        MUL  = 4'd12   // multi-cycle, handled by mulUnit
    } aluOpE;

    typedef enum logic {
        REG = 1'b0,    // busB
        IMM = 1'b1     // imm32
    } srcBSelE;

    typedef enum logic [1:0] {
        ALU = 2'd0,
        PC8 = 2'd1,    // link address
        MEM = 2'd2     // load data, picked in mem stage
    } wbSelE;

endpackage

// File: hdl/idExeReg.sv
`timescale 1ns/10ps

module idExeReg #(
    parameter int DataWidth = cpuTypesPkg::DataWidth
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    wr,
    input  cpuTypesPkg::wordT       busA,
    input  cpuTypesPkg::wordT       busB,
    input  cpuTypesPkg::wordT       imm32,
    input  cpuTypesPkg::wordT       pc,
    input  cpuTypesPkg::regAddrT    rd,
    input  exeCtrlPkg::aluOpE       aluOp,
    input  exeCtrlPkg::srcBSelE     srcBSel,
    input  exeCtrlPkg::wbSelE       wbSel,
    input  logic                    regWr,
    output cpuTypesPkg::wordT       exeBusA,
    output cpuTypesPkg::wordT       exeBusB,
    output cpuTypesPkg::wordT       exeImm32,
    output cpuTypesPkg::wordT       exePc,
    output cpuTypesPkg::regAddrT    exeRd,
    output exeCtrlPkg::aluOpE       exeAluOp,
    output exeCtrlPkg::srcBSelE     exeSrcBSel,
    output exeCtrlPkg::wbSelE       exeWbSel,
    output logic                    exeRegWr,
    output cpuTypesPkg::shamtT      exeShamt
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            exeBusA    <= {DataWidth{1'b0}};
            exeBusB    <= {DataWidth{1'b0}};
            exeImm32   <= {DataWidth{1'b0}};
            exePc      <= {DataWidth{1'b0}};
            exeRd      <= '0;
            exeAluOp   <= exeCtrlPkg::ADD;
            exeSrcBSel <= exeCtrlPkg::REG;
            exeWbSel   <= exeCtrlPkg::ALU;
            exeRegWr   <= 1'b0;
            exeShamt   <= '0;
        end else if (flush) begin    // turn the slot into a bubble
            exeBusA    <= {DataWidth{1'b0}};
            exeBusB    <= {DataWidth{1'b0}};
            exeImm32   <= {DataWidth{1'b0}};
            exePc      <= {DataWidth{1'b0}};
            exeRd      <= '0;
            exeAluOp   <= exeCtrlPkg::ADD;
            exeSrcBSel <= exeCtrlPkg::REG;
            exeWbSel   <= exeCtrlPkg::ALU;
            exeRegWr   <= 1'b0;
            exeShamt   <= '0;
        end else if (wr) begin       // low while the multiplier stalls
            exeBusA    <= busA;
            exeBusB    <= busB;
            exeImm32   <= imm32;
            exePc      <= pc;
            exeRd      <= rd;
            exeAluOp   <= aluOp;
            exeSrcBSel <= srcBSel;
            exeWbSel   <= wbSel;
            exeRegWr   <= regWr;
            exeShamt   <= imm32[10:6]; // sa field of the r-type word
        end
    end

    // a flushed instruction never reaches write-back
    flushMakesBubble: assert property (
        @(posedge clk) disable iff (!rst) flush |=> !exeRegWr
    ) else $error("idExeReg: register write survived a flush");

endmodule

// File: hdl/exeAlu.sv
`timescale 1ns/10ps

module exeAlu #(
    parameter int DataWidth = cpuTypesPkg::DataWidth
) (
    input  cpuTypesPkg::wordT      busA,
    input  cpuTypesPkg::wordT      busB,
    input  cpuTypesPkg::wordT      imm32,
    input  cpuTypesPkg::wordT      pc,
    input  cpuTypesPkg::shamtT     shamt,
    input  exeCtrlPkg::aluOpE      aluOp,
    input  exeCtrlPkg::srcBSelE    srcBSel,
    input  exeCtrlPkg::wbSelE      wbSel,
    output cpuTypesPkg::wordT      result
);

    localparam int Half = DataWidth / 2;

    logic [DataWidth-1:0] opB;
    logic [DataWidth-1:0] aluOut;
    logic                 lessSigned;
    logic                 lessUnsigned;

    assign opB = (srcBSel == exeCtrlPkg::IMM) ? imm32 : busB;

    assign lessSigned   = $signed(busA) < $signed(opB);
    assign lessUnsigned = busA < opB;

    always_comb begin
        case (aluOp)
            exeCtrlPkg::ADD:  aluOut = busA + opB;
            exeCtrlPkg::SUB:  aluOut = busA - opB;
            exeCtrlPkg::AND:  aluOut = busA & opB;
            exeCtrlPkg::OR:   aluOut = busA | opB;
            exeCtrlPkg::XOR:  aluOut = busA ^ opB;
            exeCtrlPkg::NOR:  aluOut = ~(busA | opB);
            exeCtrlPkg::SLT:  aluOut = {{(DataWidth-1){1'b0}}, lessSigned};
            exeCtrlPkg::SLTU: aluOut = {{(DataWidth-1){1'b0}}, lessUnsigned};
            exeCtrlPkg::SLL:  aluOut = opB << shamt;
            exeCtrlPkg::SRL:  aluOut = opB >> shamt;
            exeCtrlPkg::SRA:  aluOut = $signed(opB) >>> shamt;
            exeCtrlPkg::LUI:  aluOut = {imm32[Half-1:0], {(DataWidth-Half){1'b0}}};
            default:          aluOut = {DataWidth{1'b0}}; // MUL comes from mulUnit
        endcase
    end

    // jal/jalr link value skips the delay slot
    assign result = (wbSel == exeCtrlPkg::PC8) ? pc + DataWidth'(8) : aluOut;

endmodule

// File: hdl/exeMemReg.sv
`timescale 1ns/10ps

module exeMemReg #(
    parameter int DataWidth = cpuTypesPkg::DataWidth
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    mulDone,
    input  cpuTypesPkg::wordT       aluResult,
    input  cpuTypesPkg::wordT       product,
    input  cpuTypesPkg::regAddrT    rd,
    input  exeCtrlPkg::wbSelE       wbSel,
    input  logic                    regWr,
    output cpuTypesPkg::wordT       memResult,
    output cpuTypesPkg::regAddrT    memRd,
    output exeCtrlPkg::wbSelE       memWbSel,
    output logic                    memRegWr
);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            memResult <= {DataWidth{1'b0}};
            memRd     <= '0;
            memWbSel  <= exeCtrlPkg::ALU;
            memRegWr  <= 1'b0;
        end else if (stall) begin           // multiply still running
            memResult <= {DataWidth{1'b0}};
            memRd     <= '0;
            memWbSel  <= exeCtrlPkg::ALU;
            memRegWr  <= 1'b0;
        end else begin
            memResult <= mulDone ? product : aluResult;
            memRd     <= rd;
            memWbSel  <= wbSel;
            memRegWr  <= regWr;
        end
    end

endmodule

// File: mulUnit/mulStepCounter.sv
`timescale 1ns/10ps

module mulStepCounter #(
    parameter int DataWidth = cpuTypesPkg::DataWidth
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic step,
    input  logic clear,
    output logic lastStep
);

    localparam int CountWidth = (DataWidth > 1) ? $clog2(DataWidth) : 1;

    logic [CountWidth-1:0] count;   // steps left after the current one

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;                         // abandoned multiply
        end else if (start) begin
            count <= CountWidth'(DataWidth - 1);
        end else if (step) begin
            count <= count - 1'b1;
        end
    end

    assign lastStep = (count == '0);

    // the FSM must stop stepping once the count has run out
    noStepPastZero: assert property (
        @(posedge clk) disable iff (!rst) !(step && !start && count == '0)
    ) else $error("mulStepCounter: step with count already at zero");

endmodule

// File: mulUnit/mulStallFsm.sv
`timescale 1ns/10ps

module mulStallFsm #(
    parameter int DataWidth = cpuTypesPkg::DataWidth
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,
    input  logic                lastStep,
    input  exeCtrlPkg::aluOpE   exeAluOp,
    output logic                start,
    output logic                step,
    output logic                stall,
    output logic                mulDone
);

    typedef enum logic {IDLE, BUSY} stateE;

    stateE state;
    stateE nextState;
    logic  isMul;

    assign isMul = (exeAluOp == exeCtrlPkg::MUL);

    always_comb begin
        nextState = state;
        start     = 1'b0;
        step      = 1'b0;
        stall     = 1'b0;
        mulDone   = 1'b0;
        case (state)
            IDLE: begin
                stall = isMul;               // hold ID so the MUL is not issued twice
                start = isMul && !flush;
                if (start) begin
                    nextState = BUSY;
                end
            end
            BUSY: begin
                if (lastStep && !flush) begin
                    mulDone   = 1'b1;        // final bit is added combinationally
                    nextState = IDLE;
                end else begin
                    step  = !flush;
                    stall = 1'b1;
                end
            end
            default: nextState = IDLE;
        endcase
        if (flush) begin
            nextState = IDLE;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    // a started multiply ends within DataWidth cycles unless it is flushed
    mulFinishes: assert property (
        @(posedge clk) disable iff (!rst)
        start |-> ##[1:DataWidth] (mulDone || flush)
    ) else $error("mulStallFsm: multiply did not complete in time");

    // completion needs a busy cycle right before it
    doneAfterBusy: assert property (
        @(posedge clk) disable iff (!rst) mulDone |-> $past(state) == BUSY
    ) else $error("mulStallFsm: mulDone without a running multiply");

endmodule

// File: mulUnit/mulIterative.sv
`timescale 1ns/10ps

module mulIterative #(
    parameter int DataWidth = cpuTypesPkg::DataWidth
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                start,
    input  logic                step,
    input  cpuTypesPkg::wordT   multiplicand,
    input  cpuTypesPkg::wordT   multiplier,
    output cpuTypesPkg::wordT   product
);

    // only the low word is kept, so all registers are one word wide
    logic [DataWidth-1:0] acc;
    logic [DataWidth-1:0] mcand;    // multiplicand, moves left one bit per step
    logic [DataWidth-1:0] mplier;   // multiplier, current bit at lsb
    logic [DataWidth-1:0] partial;

    assign partial = mplier[0] ? mcand : {DataWidth{1'b0}};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            acc    <= {DataWidth{1'b0}};
            mcand  <= {DataWidth{1'b0}};
            mplier <= {DataWidth{1'b0}};
        end else if (start) begin
            acc    <= {DataWidth{1'b0}};
            mcand  <= multiplicand;
            mplier <= multiplier;
        end else if (step) begin
            acc    <= acc + partial;
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
        end
    end

    // the last step is not registered
    assign product = acc + partial;

endmodule

// File: hdl/exeStage.sv
`timescale 1ns/10ps

module exeStage #(
    parameter int DataWidth = cpuTypesPkg::DataWidth
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  cpuTypesPkg::wordT       busA,
    input  cpuTypesPkg::wordT       busB,
    input  cpuTypesPkg::wordT       imm32,
    input  cpuTypesPkg::wordT       pc,
    input  cpuTypesPkg::regAddrT    rd,
    input  exeCtrlPkg::aluOpE       aluOp,
    input  exeCtrlPkg::srcBSelE     srcBSel,
    input  exeCtrlPkg::wbSelE       wbSel,
    input  logic                    regWr,
    output cpuTypesPkg::wordT       memResult,
    output cpuTypesPkg::regAddrT    memRd,
    output exeCtrlPkg::wbSelE       memWbSel,
    output logic                    memRegWr,
    output logic                    stall
);

    cpuTypesPkg::wordT      exeBusA;
    cpuTypesPkg::wordT      exeBusB;
    cpuTypesPkg::wordT      exeImm32;
    cpuTypesPkg::wordT      exePc;
    cpuTypesPkg::regAddrT   exeRd;
    exeCtrlPkg::aluOpE      exeAluOp;
    exeCtrlPkg::srcBSelE    exeSrcBSel;
    exeCtrlPkg::wbSelE      exeWbSel;
    logic                   exeRegWr;
    cpuTypesPkg::shamtT     exeShamt;
    cpuTypesPkg::wordT      aluResult;
    cpuTypesPkg::wordT      product;
    logic                   start;
    logic                   step;
    logic                   lastStep;
    logic                   mulDone;

    idExeReg #(.DataWidth(DataWidth)) idExeReg_i (
        .clk(clk), .rst(rst), .flush(flush), .wr(!stall),
        .busA(busA), .busB(busB), .imm32(imm32), .pc(pc), .rd(rd),
        .aluOp(aluOp), .srcBSel(srcBSel), .wbSel(wbSel), .regWr(regWr),
        .exeBusA(exeBusA), .exeBusB(exeBusB), .exeImm32(exeImm32), .exePc(exePc),
        .exeRd(exeRd), .exeAluOp(exeAluOp), .exeSrcBSel(exeSrcBSel),
        .exeWbSel(exeWbSel), .exeRegWr(exeRegWr), .exeShamt(exeShamt)
    );

    exeAlu #(.DataWidth(DataWidth)) exeAlu_i (
        .busA(exeBusA), .busB(exeBusB), .imm32(exeImm32), .pc(exePc),
        .shamt(exeShamt), .aluOp(exeAluOp), .srcBSel(exeSrcBSel),
        .wbSel(exeWbSel), .result(aluResult)
    );

    mulStallFsm #(.DataWidth(DataWidth)) mulStallFsm_i (
        .clk(clk), .rst(rst), .flush(flush), .lastStep(lastStep),
        .exeAluOp(exeAluOp), .start(start), .step(step), .stall(stall),
        .mulDone(mulDone)
    );

    mulStepCounter #(.DataWidth(DataWidth)) mulStepCounter_i (
        .clk(clk), .rst(rst), .start(start), .step(step), .clear(flush),
        .lastStep(lastStep)
    );

    mulIterative #(.DataWidth(DataWidth)) mulIterative_i (
        .clk(clk), .rst(rst), .start(start), .step(step),
        .multiplicand(exeBusA), .multiplier(exeBusB), .product(product)
    );

    exeMemReg #(.DataWidth(DataWidth)) exeMemReg_i (
        .clk(clk), .rst(rst), .stall(stall), .mulDone(mulDone),
        .aluResult(aluResult), .product(product), .rd(exeRd),
        .wbSel(exeWbSel), .regWr(exeRegWr), .memResult(memResult),
        .memRd(memRd), .memWbSel(memWbSel), .memRegWr(memRegWr)
    );

endmodule

// File: testbench/exeStageTb.sv
`timescale 1ns/10ps

module exeStageTb;

    localparam int DataWidth  = cpuTypesPkg::DataWidth;
    localparam int StallLimit = 3 * DataWidth;   // cycles
    localparam int DrainLimit = 4 * DataWidth;

    logic                   clk;
    logic                   rst;
    logic                   flush;
    cpuTypesPkg::wordT      busA;
    cpuTypesPkg::wordT      busB;
    cpuTypesPkg::wordT      imm32;
    cpuTypesPkg::wordT      pc;
    cpuTypesPkg::regAddrT   rd;
    exeCtrlPkg::aluOpE      aluOp;
    exeCtrlPkg::srcBSelE    srcBSel;
    exeCtrlPkg::wbSelE      wbSel;
    logic                   regWr;
    cpuTypesPkg::wordT      memResult;
    cpuTypesPkg::regAddrT   memRd;
    exeCtrlPkg::wbSelE      memWbSel;
    logic                   memRegWr;
    logic                   stall;

    cpuTypesPkg::wordT      expResultQ[$];   // oldest instruction first
    cpuTypesPkg::regAddrT   expRdQ[$];
    exeCtrlPkg::wbSelE      expWbSelQ[$];
    logic [31:0]            rngState;

    exeStage #(.DataWidth(DataWidth)) dut_i (
        .clk(clk), .rst(rst), .flush(flush), .busA(busA), .busB(busB), .imm32(imm32),
        .pc(pc), .rd(rd), .aluOp(aluOp), .srcBSel(srcBSel), .wbSel(wbSel), .regWr(regWr),
        .memResult(memResult), .memRd(memRd), .memWbSel(memWbSel), .memRegWr(memRegWr),
        .stall(stall)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift32(rngState);
        return rngState;
    endfunction

    // expected write-back value of one instruction
    function automatic cpuTypesPkg::wordT expectedResult(
        input exeCtrlPkg::aluOpE op, input cpuTypesPkg::wordT a, b, imm, pcVal,
        input exeCtrlPkg::srcBSelE sel, input exeCtrlPkg::wbSelE wb
    );
        cpuTypesPkg::wordT opB;
        int unsigned       sa;
        opB = (sel == exeCtrlPkg::IMM) ? imm : b;
        sa  = imm[10:6];                           // sa field
        if (op == exeCtrlPkg::MUL) return a * b;   // low word only
        if (wb == exeCtrlPkg::PC8) return pcVal + 8;
        case (op)
            exeCtrlPkg::ADD:  return a + opB;
            exeCtrlPkg::SUB:  return a - opB;
            exeCtrlPkg::AND:  return a & opB;
            exeCtrlPkg::OR:   return a | opB;
            exeCtrlPkg::XOR:  return a ^ opB;
            exeCtrlPkg::NOR:  return ~(a | opB);
            exeCtrlPkg::SLT:  return ($signed(a) < $signed(opB)) ? 1 : 0;
            exeCtrlPkg::SLTU: return (a < opB) ? 1 : 0;
            exeCtrlPkg::SLL:  return opB << sa;
            exeCtrlPkg::SRL:  return opB >> sa;
            exeCtrlPkg::SRA:  return $signed(opB) >>> sa;
            exeCtrlPkg::LUI:  return imm << (DataWidth / 2);
            default:          return '0;
        endcase
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkWord(input cpuTypesPkg::wordT actual, expected, input string what);
        if (actual !== expected) begin
            failRun($sformatf("Error at %0t ns: %s is %h, expected %h",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkRegAddr(input cpuTypesPkg::regAddrT actual, expected,
                                input string what);
        if (actual !== expected) begin
            failRun($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                              $time, what, actual, expected));
        end
    endtask

    task automatic checkWbSel(input exeCtrlPkg::wbSelE actual, expected,
                              input string what);
        if (actual !== expected) begin
            failRun($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                              $time, what, actual, expected));
        end
    endtask

    task automatic driveInputs(
        input exeCtrlPkg::aluOpE op, input cpuTypesPkg::wordT a, b, imm, pcVal,
        input cpuTypesPkg::regAddrT rdVal, input exeCtrlPkg::srcBSelE sel,
        input exeCtrlPkg::wbSelE wb, input logic wr
    );
        aluOp   = op;
        busA    = a;
        busB    = b;
        imm32   = imm;
        pc      = pcVal;
        rd      = rdVal;
        srcBSel = sel;
        wbSel   = wb;
        regWr   = wr;
    endtask

    task automatic driveBubble();
        driveInputs(exeCtrlPkg::ADD, '0, '0, '0, '0, '0, exeCtrlPkg::REG, exeCtrlPkg::ALU, 1'b0);
    endtask

    // one instruction at the ID inputs until the pipe takes it
    task automatic issue(
        input exeCtrlPkg::aluOpE op, input cpuTypesPkg::wordT a, b, imm, pcVal,
        input cpuTypesPkg::regAddrT rdVal, input exeCtrlPkg::srcBSelE sel,
        input exeCtrlPkg::wbSelE wb, input logic wr, input logic keep,
        output int stallCycles
    );
        int waited;
        @(negedge clk);
        driveInputs(op, a, b, imm, pcVal, rdVal, sel, wb, wr);
        waited = 0;
        while (stall) begin                    // ID holds while EXE is busy
            waited++;
            if (waited > StallLimit) begin
                failRun("Timed out waiting for stall to drop");
            end
            @(negedge clk);
        end
        stallCycles = waited;
        if (wr && keep) begin
            expResultQ.push_back(expectedResult(op, a, b, imm, pcVal, sel, wb));
            expRdQ.push_back(rdVal);
            expWbSelQ.push_back(wb);
        end
    endtask

    task automatic issueRandom(output int stallCycles);
        logic [31:0]       r;
        cpuTypesPkg::wordT a;
        cpuTypesPkg::wordT b;
        cpuTypesPkg::wordT imm;
        cpuTypesPkg::wordT pcVal;
        r     = nextRandom();
        a     = nextRandom();
        b     = nextRandom();
        imm   = nextRandom();
        pcVal = nextRandom();
        issue(exeCtrlPkg::aluOpE'(r % 12), a, b, imm, pcVal, cpuTypesPkg::regAddrT'(r[20:16]),
              exeCtrlPkg::srcBSelE'(r[8]), exeCtrlPkg::wbSelE'(r[13:12] % 3),
              (r[26:24] != 3'd0), 1'b1, stallCycles);  // one in eight is a bubble
    endtask

    task automatic issueShift(input exeCtrlPkg::aluOpE op);
        cpuTypesPkg::wordT a;
        cpuTypesPkg::wordT b;
        cpuTypesPkg::wordT imm;
        int                stallCycles;
        a   = nextRandom();
        b   = nextRandom();
        imm = nextRandom();
        issue(op, a, b, imm, '0, cpuTypesPkg::regAddrT'(imm[31:27]), exeCtrlPkg::REG,
              exeCtrlPkg::ALU, 1'b1, 1'b1, stallCycles);
    endtask

    task automatic issueMul(input cpuTypesPkg::wordT a, b, input logic keep,
                            output int stallCycles);
        cpuTypesPkg::wordT imm;
        imm = nextRandom();
        issue(exeCtrlPkg::MUL, a, b, imm, '0, cpuTypesPkg::regAddrT'(imm[4:0]),
              exeCtrlPkg::REG, exeCtrlPkg::ALU, 1'b1, keep, stallCycles);
    endtask

    task automatic drain();
        int waited;
        @(negedge clk);
        driveBubble();
        waited = 0;
        while (expResultQ.size() != 0) begin
            waited++;
            if (waited > DrainLimit) begin
                failRun("Timed out waiting for expected results at the memory stage");
            end
            @(negedge clk);
        end
        repeat (3) @(negedge clk);              // room for a stray write to show
    endtask

    // compares every register write against the oldest expected result
    initial begin
        cpuTypesPkg::wordT    expWord;
        cpuTypesPkg::regAddrT expRd;
        exeCtrlPkg::wbSelE    expWbSel;
        forever begin
            @(negedge clk);
            if (rst && memRegWr) begin
                if (expResultQ.size() == 0) begin
                    failRun("A register write reached the memory stage unexpectedly");
                end else begin
                    expWord  = expResultQ.pop_front();
                    expRd    = expRdQ.pop_front();
                    expWbSel = expWbSelQ.pop_front();
                    checkWord(memResult, expWord, "memResult");
                    checkRegAddr(memRd, expRd, "memRd");
                    checkWbSel(memWbSel, expWbSel, "memWbSel");
                end
            end
        end
    end

    initial begin
        int stallCycles;
        rngState = 32'd27;
        rst      = 1'b0;
        flush    = 1'b0;
        driveBubble();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        if (memRegWr !== 1'b0 || stall !== 1'b0) begin
            failRun("memRegWr or stall is not low after reset");
        end

        repeat (300) issueRandom(stallCycles);
        drain();

        repeat (12) begin
            issueShift(exeCtrlPkg::SLL);
            issueShift(exeCtrlPkg::SRL);
            issueShift(exeCtrlPkg::SRA);
        end
        drain();

        issueMul('1, '1, 1'b1, stallCycles);
        for (int i = 0; i < 6; i++) begin
            issueMul(nextRandom(), nextRandom(), 1'b1, stallCycles);
            if (i >= 2) begin
                issueRandom(stallCycles);      // waits behind the multiply
                if (stallCycles != DataWidth) begin
                    failRun($sformatf("stall was high for %0d cycles in a multiply, not %0d",
                                      stallCycles, DataWidth));
                end
            end
        end
        drain();

        // instruction presented together with flush is dropped
        issueRandom(stallCycles);
        @(negedge clk);
        driveInputs(exeCtrlPkg::OR, nextRandom(), nextRandom(), '0, '0, 5'd9,
                    exeCtrlPkg::REG, exeCtrlPkg::ALU, 1'b1);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        driveBubble();
        drain();

        // flush abandons a running multiply
        issueMul(nextRandom(), nextRandom(), 1'b0, stallCycles);
        @(negedge clk);
        driveBubble();
        for (int i = 0; i < 6; i++) begin
            if (stall !== 1'b1) begin
                failRun("stall dropped while a multiply was running");
            end
            @(negedge clk);
        end
        flush = 1'b1;
        @(negedge clk);
        if (stall !== 1'b0) begin
            failRun("stall is still high after a flush during a multiply");
        end
        flush = 1'b0;
        repeat (8) issueRandom(stallCycles);
        drain();

        $display("No errors");
        $finish;
    end

endmodule

// File: filelist.f
common/cpuTypesPkg.sv
common/exeCtrlPkg.sv
hdl/idExeReg.sv
hdl/exeAlu.sv
hdl/exeMemReg.sv
mulUnit/mulStepCounter.sv
mulUnit/mulStallFsm.sv
mulUnit/mulIterative.sv
hdl/exeStage.sv
testbench/exeStageTb.sv
